// ==== common/rvcDecodePkg.sv ====
// decoder types: both views of an RVC word, the classified word,
// the finished micro-op and the immediate kinds
`include "rvcDecode_params.svh"

package rvcDecodePkg;

	// layout with 5-bit register fields
	typedef struct packed {
		logic [2:0] funct3;
		logic bit12;
		logic [4:0] rd;
		logic [4:0] rs2;
		logic [1:0] quadrant;
	} rvcFullS;

	// layout with 3-bit register fields
	typedef struct packed {
		logic [2:0] funct3;
		logic [2:0] hi3;
		logic [2:0] rs1c; // rd'/rs1' at 9:7
		logic [1:0] mid2;
		logic [2:0] rdc; // rd'/rs2' at 4:2
		logic [1:0] quadrant;
	} rvcCompactS;

	typedef union packed {
		rvcFullS full;
		rvcCompactS compact;
	} rvcWordU;

	// one classified word as it travels through the FIFO
	typedef struct packed {
		rvcWordU word;
		logic [5:0] nmid;
		logic [4:0] fmid;
		logic [3:0] ity;
		logic [2:0] bty;
		logic [5:0] ucmdIx;
	} rvcClassS;

	typedef struct packed {
		logic [8:0] uCmd; // condition code above class
		logic [8:0] uIxt;
		logic [`RVC_GPR_W-1:0] regN;
		logic [`RVC_GPR_W-1:0] regM;
		logic [`RVC_GPR_W-1:0] regO;
		logic [32:0] imm;
	} rvcUopS;

	typedef enum logic [3:0] {
		immNone = 4'd0,
		imm6Alu = 4'd1,
		imm4Lw = 4'd2,
		imm4Qw = 4'd3,
		imm6LwLd = 4'd4,
		imm6QwLd = 4'd5,
		imm6LwSt = 4'd6,
		imm6QwSt = 4'd7,
		imm6A16Sp = 4'd8,
		imm6Lui = 4'd9,
		imm11J = 4'd10,
		imm8Jcc = 4'd11
	} rvcImmKindE;

endpackage

// ==== common/rvcDecode_params.svh ====
// register numbers, micro-op classes and operand forms
// sub-op, index type, access width and condition codes, FIFO depth
`ifndef RVC_DECODE_PARAMS_SVH
`define RVC_DECODE_PARAMS_SVH

`define RVC_GPR_W 7

// plain GPRs
`define RVC_GR_R2 7'h02
`define RVC_GR_R3 7'h03
`define RVC_GR_R4 7'h04
`define RVC_GR_R5 7'h05
`define RVC_GR_R7 7'h07
`define RVC_GR_R8 7'h08
`define RVC_GR_R9 7'h09
`define RVC_GR_R10 7'h0A
`define RVC_GR_R11 7'h0B
`define RVC_GR_R12 7'h0C
`define RVC_GR_R13 7'h0D
`define RVC_GR_SP 7'h0F

// special registers, kept clear of the direct range 16..31
`define RVC_GR_ZZR 7'h40
`define RVC_GR_LR 7'h41
`define RVC_GR_GBR 7'h42
`define RVC_GR_DLR 7'h43
`define RVC_GR_IMM 7'h44 // operand comes from the immediate
`define RVC_GR_BPC 7'h45

`define RVC_UCMD_NOP 6'h00
`define RVC_UCMD_MOV_RM 6'h01
`define RVC_UCMD_MOV_MR 6'h02
`define RVC_UCMD_MOV_IR 6'h03
`define RVC_UCMD_ALU3 6'h04
`define RVC_UCMD_BRA 6'h08
`define RVC_UCMD_JMP 6'h09
`define RVC_UCMD_JSR 6'h0A
`define RVC_UCMD_JCMP 6'h0B
`define RVC_UCMD_OP_IXT 6'h0C
`define RVC_UCMD_INVOP 6'h3F

`define RVC_FMID_INV 5'h00
`define RVC_FMID_Z 5'h01
`define RVC_FMID_REG 5'h02
`define RVC_FMID_REGREG 5'h03
`define RVC_FMID_LDREGDISPREG 5'h04
`define RVC_FMID_LDDI4SPREG 5'h05
`define RVC_FMID_IMM8REG 5'h06
`define RVC_FMID_REGPC 5'h07
`define RVC_FMID_PCDISP8 5'h08

`define RVC_UCIX_ADD 6'h00
`define RVC_UCIX_SUB 6'h01
`define RVC_UCIX_ADDSL 6'h02
`define RVC_UCIX_SUBSL 6'h03
`define RVC_UCIX_AND 6'h05
`define RVC_UCIX_OR 6'h06
`define RVC_UCIX_XOR 6'h07
`define RVC_UCIX_LDIX 6'h10
`define RVC_UCIX_JCMP_QEQ 6'h20
`define RVC_UCIX_JCMP_QNE 6'h21
`define RVC_UCIX_IXT_SYSE 6'h30

`define RVC_ITY_SB 4'h0
`define RVC_ITY_SW 4'h1
`define RVC_ITY_UB 4'h2
`define RVC_ITY_UW 4'h3

`define RVC_BTY_SW 3'b010 // 32-bit access
`define RVC_BTY_SQ 3'b011 // 64-bit access

`define RVC_IXC_AL 3'b000
`define RVC_IUC_SC 3'b001

`define RVC_FIFO_DEPTH 4

`endif

// ==== list.f ====
+incdir+common
common/rvcDecodePkg.sv
operand/rvcRegMap.sv
operand/rvcImmGen.sv
src/rvcClassify.sv
src/rvcOpFifo.sv
operand/rvcOperandForm.sv
src/rvcDecodeTop.sv
sim/rvcDecode_properties.sv
sim/rvcDecodeTb.sv

// ==== operand/rvcImmGen.sv ====
// immediate gathering for all RVC layouts, kind select
// and sign extension to 33 bits
`timescale 1ns/10ps

module rvcImmGen (
	input rvcDecodePkg::rvcWordU word,
	input rvcDecodePkg::rvcImmKindE kind,
	output logic [32:0] imm
);

	logic [11:0] alu6;
	logic [11:0] ofs4Lw;
	logic [11:0] ofs4Qw;
	logic [11:0] ofs6LwLd;
	logic [11:0] ofs6QwLd;
	logic [11:0] ofs6LwSt;
	logic [11:0] ofs6QwSt;
	logic [11:0] a16Sp;
	logic [11:0] jmp;
	logic [11:0] bcc;
	logic [11:0] sel;

	assign alu6 = {{7{word[12]}}, word[6:2]};
	assign ofs4Lw = {5'b0, word[5], word[12:10], word[6], 2'b00};
	assign ofs4Qw = {4'b0, word[6:5], word[12:10], 3'b000};
	assign ofs6LwLd = {4'b0, word[3:2], word[12], word[6:4], 2'b00};
	assign ofs6QwLd = {3'b0, word[4:2], word[12], word[6:5], 3'b000};
	assign ofs6LwSt = {4'b0, word[8:7], word[12:9], 2'b00};
	assign ofs6QwSt = {3'b0, word[9:7], word[12:10], 3'b000};
	assign a16Sp = {{3{word[12]}}, word[4:3], word[5], word[2], word[6], 4'h0};

	// scrambled jump and branch offsets, bit 0 always zero
	assign jmp = {word[12], word[8], word[10], word[9], word[6], word[7],
		word[2], word[11], word[5], word[4], word[3], 1'b0};
	assign bcc = {{4{word[12]}}, word[6:5], word[2], word[11:10], word[4:3], 1'b0};

	always_comb begin
		case (kind)
			rvcDecodePkg::imm6Alu: sel = alu6;
			rvcDecodePkg::imm4Lw: sel = ofs4Lw;
			rvcDecodePkg::imm4Qw: sel = ofs4Qw;
			rvcDecodePkg::imm6LwLd: sel = ofs6LwLd;
			rvcDecodePkg::imm6QwLd: sel = ofs6QwLd;
			rvcDecodePkg::imm6LwSt: sel = ofs6LwSt;
			rvcDecodePkg::imm6QwSt: sel = ofs6QwSt;
			rvcDecodePkg::imm6A16Sp: sel = a16Sp;
			rvcDecodePkg::imm11J: sel = {jmp[11], jmp[11:1]}; // halved
			rvcDecodePkg::imm8Jcc: sel = {bcc[11], bcc[11:1]};
			default: sel = '0; // none, lui handled below
		endcase
	end

	// upper immediate sits 12 bits up, the rest sign-extends from bit 11
	assign imm = (kind == rvcDecodePkg::imm6Lui) ?
		{{9{alu6[11]}}, alu6, 12'h000} : {{21{sel[11]}}, sel};

endmodule

// ==== operand/rvcOperandForm.sv ====
// consumer stage: operand and immediate choice per form,
// registered micro-op output
`timescale 1ns/10ps
`include "rvcDecode_params.svh"

module rvcOperandForm (
	input logic clock,
	input logic rstN,
	input logic qValid,
	output logic qReady,
	input rvcDecodePkg::rvcClassS qHead,
	output logic outValid,
	input logic outReady,
	output rvcDecodePkg::rvcUopS uop
);

	logic [`RVC_GPR_W-1:0] rdFull;
	logic [`RVC_GPR_W-1:0] rs2Full;
	logic [`RVC_GPR_W-1:0] rdCompact;
	logic [`RVC_GPR_W-1:0] rs2Compact;
	logic [32:0] imm;
	logic isQw;
	logic [8:0] memIxt;
	localparam logic [8:0] brIxt = {`RVC_IUC_SC, 2'b01, 1'b1, 3'b001};
	rvcDecodePkg::rvcImmKindE kind;
	rvcDecodePkg::rvcUopS nxt;

	rvcRegMap regMap (
		.word(qHead.word),
		.rdFull(rdFull),
		.rs2Full(rs2Full),
		.rdCompact(rdCompact),
		.rs2Compact(rs2Compact)
	);

	rvcImmGen immGen (
		.word(qHead.word),
		.kind(kind),
		.imm(imm)
	);

	assign isQw = (qHead.bty[1:0] == 2'b11);
	assign memIxt = {`RVC_IUC_SC, qHead.bty[1:0], 1'b0, 3'b000};

	always_comb begin
		nxt.uCmd = {`RVC_IXC_AL, qHead.nmid};
		nxt.uIxt = {`RVC_IUC_SC, qHead.ucmdIx};
		nxt.regN = `RVC_GR_ZZR;
		nxt.regM = `RVC_GR_ZZR;
		nxt.regO = `RVC_GR_ZZR;
		kind = rvcDecodePkg::immNone;
		case (qHead.fmid)
			`RVC_FMID_Z: ; // all ZZR, no immediate
			`RVC_FMID_REG: begin
				nxt.regM = rdFull; // jump target
				nxt.regN = `RVC_GR_LR;
			end
			`RVC_FMID_REGREG: begin
				nxt.regN = (qHead.ity == `RVC_ITY_UB) ? rdCompact : rdFull;
				nxt.regM = (qHead.ity == `RVC_ITY_UB) ? rdCompact : rdFull;
				nxt.regO = (qHead.ity == `RVC_ITY_UB) ? rs2Compact : rs2Full;
			end
			`RVC_FMID_LDREGDISPREG: begin
				nxt.uIxt = memIxt;
				nxt.regO = `RVC_GR_IMM;
				kind = isQw ? rvcDecodePkg::imm4Qw : rvcDecodePkg::imm4Lw;
				// stores swap base and data register
				nxt.regM = (qHead.ity == `RVC_ITY_UB) ? rdCompact : rs2Compact;
				nxt.regN = (qHead.ity == `RVC_ITY_UB) ? rs2Compact : rdCompact;
			end
			`RVC_FMID_LDDI4SPREG: begin
				nxt.uIxt = memIxt;
				nxt.regM = `RVC_GR_SP;
				nxt.regO = `RVC_GR_IMM;
				if (qHead.ity == `RVC_ITY_UB) begin
					nxt.regN = rs2Full;
					kind = isQw ? rvcDecodePkg::imm6QwSt : rvcDecodePkg::imm6LwSt;
				end else begin
					nxt.regN = rdFull;
					kind = isQw ? rvcDecodePkg::imm6QwLd : rvcDecodePkg::imm6LwLd;
				end
			end
			`RVC_FMID_IMM8REG: begin
				nxt.regN = (qHead.ity == `RVC_ITY_UW) ? rdCompact : rdFull;
				nxt.regM = (qHead.ity == `RVC_ITY_UW) ? rdCompact : rdFull;
				nxt.regO = `RVC_GR_IMM;
				case (qHead.ity)
					`RVC_ITY_SW: kind = rvcDecodePkg::imm6Lui;
					`RVC_ITY_UB: kind = rvcDecodePkg::imm6A16Sp;
					default: kind = rvcDecodePkg::imm6Alu;
				endcase
			end
			`RVC_FMID_REGPC: begin
				nxt.uIxt = brIxt;
				kind = rvcDecodePkg::imm8Jcc;
				// compare-with-zero branches test rs1' instead of BPC
				nxt.regM = (qHead.ity == `RVC_ITY_UW) ? rdCompact : `RVC_GR_BPC;
				nxt.regO = (qHead.ity == `RVC_ITY_UW) ? `RVC_GR_ZZR : rdFull;
			end
			`RVC_FMID_PCDISP8: begin
				nxt.uIxt = brIxt;
				nxt.regM = `RVC_GR_BPC;
				nxt.regO = `RVC_GR_IMM;
				kind = rvcDecodePkg::imm11J;
			end
			default: begin // INV and any unknown form
				nxt.uCmd = {`RVC_IXC_AL, `RVC_UCMD_INVOP};
				nxt.uIxt = '0;
			end
		endcase
		nxt.imm = imm;
	end

	assign qReady = !outValid || outReady;

	always_ff @(posedge clock) begin
		if (!rstN)
			outValid <= 1'b0;
		else if (qReady)
			outValid <= qValid;
	end

	always_ff @(posedge clock) begin
		if (qValid && qReady)
			uop <= nxt;
	end

endmodule

// ==== operand/rvcRegMap.sv ====
// register-number maps for 5-bit and compact 3-bit fields
`timescale 1ns/10ps
`include "rvcDecode_params.svh"

module rvcRegMap (
	input rvcDecodePkg::rvcWordU word,
	output logic [`RVC_GPR_W-1:0] rdFull,
	output logic [`RVC_GPR_W-1:0] rs2Full,
	output logic [`RVC_GPR_W-1:0] rdCompact,
	output logic [`RVC_GPR_W-1:0] rs2Compact
);

	// low half of the register space, upper eight entries double as compact map
	function automatic logic [`RVC_GPR_W-1:0] mapLow(input logic [3:0] idx);
		case (idx)
			4'h0: mapLow = `RVC_GR_ZZR;
			4'h1: mapLow = `RVC_GR_LR;
			4'h2: mapLow = `RVC_GR_SP;
			4'h3: mapLow = `RVC_GR_GBR;
			4'h4: mapLow = `RVC_GR_R4;
			4'h5: mapLow = `RVC_GR_R5;
			4'h6: mapLow = `RVC_GR_DLR;
			4'h7: mapLow = `RVC_GR_R7;
			4'h8: mapLow = `RVC_GR_R8;
			4'h9: mapLow = `RVC_GR_R9;
			4'hA: mapLow = `RVC_GR_R10;
			4'hB: mapLow = `RVC_GR_R11;
			4'hC: mapLow = `RVC_GR_R12;
			4'hD: mapLow = `RVC_GR_R13;
			4'hE: mapLow = `RVC_GR_R2;
			4'hF: mapLow = `RVC_GR_R3;
		endcase
	endfunction

	function automatic logic [`RVC_GPR_W-1:0] mapFull(input logic [4:0] f);
		return f[4] ? {2'b00, f} : mapLow(f[3:0]); // x16..x31 pass straight
	endfunction

	assign rdFull = mapFull(word.full.rd);
	assign rs2Full = mapFull(word.full.rs2);
	assign rdCompact = mapLow({1'b1, word.compact.rs1c});
	assign rs2Compact = mapLow({1'b1, word.compact.rdc});

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the RVC decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module rvcDecodeTb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "^test passed$" sim.log; then
	exit 0
fi
exit 1

// ==== sim/rvcDecodeTb.sv ====
// testbench for the RVC decoder: LFSR stimulus, reference model,
// scoreboard queue and closing report
`timescale 1ns/10ps
`include "rvcDecode_params.svh"

module rvcDecodeTb;

	localparam int waitLimit = 200;
	localparam int numRandom = 200;
	localparam int maxInFlight = `RVC_FIFO_DEPTH + 2; // producer and output registers too

	logic clock;
	logic rstN;
	logic inValid;
	logic inReady;
	rvcDecodePkg::rvcWordU inWord;
	logic outValid;
	logic outReady;
	rvcDecodePkg::rvcUopS uop;

	logic [31:0] lfsr = 32'h9077_0c28;
	rvcDecodePkg::rvcUopS expQ[$];
	int errors = 0;
	int sent = 0;
	int received = 0;
	int inFlight = 0;
	logic timedOut = 1'b0;
	logic holdOut = 1'b0; // keeps outReady low while set

	rvcDecodeTop dut (
		.clock(clock),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inWord(inWord),
		.outValid(outValid),
		.outReady(outReady),
		.uop(uop)
	);

	always #4 clock = !clock;

	// galois LFSR, one step per bit taken
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[14:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [32:0] signExt(input logic [32:0] v, input int top);
		for (int i = top + 1; i < 33; i++)
			v[i] = v[top];
		return v;
	endfunction

	// 3-bit compact field: x8..x13 then x2, x3
	function automatic logic [6:0] compactReg(input logic [2:0] f);
		logic [6:0] tab [8];
		tab = '{`RVC_GR_R8, `RVC_GR_R9, `RVC_GR_R10, `RVC_GR_R11,
			`RVC_GR_R12, `RVC_GR_R13, `RVC_GR_R2, `RVC_GR_R3};
		return tab[f];
	endfunction

	function automatic logic [6:0] fullReg(input logic [4:0] f);
		logic [6:0] low [8];
		low = '{`RVC_GR_ZZR, `RVC_GR_LR, `RVC_GR_SP, `RVC_GR_GBR,
			`RVC_GR_R4, `RVC_GR_R5, `RVC_GR_DLR, `RVC_GR_R7};
		if (f[4])
			return {2'b00, f};
		else if (f[3])
			return compactReg(f[2:0]);
		return low[f[2:0]];
	endfunction

	// expected micro-op straight from the decode rules
	function automatic rvcDecodePkg::rvcUopS model(input logic [15:0] w);
		rvcDecodePkg::rvcUopS u;
		logic [5:0] cmd;
		logic [8:0] ixt;
		logic [6:0] rd;
		logic [6:0] rs2;
		logic [6:0] c97;
		logic [6:0] c42;
		logic [32:0] alu6;
		logic [32:0] raw;
		rd = fullReg(w[11:7]);
		rs2 = fullReg(w[6:2]);
		c97 = compactReg(w[9:7]);
		c42 = compactReg(w[4:2]);
		alu6 = signExt({27'b0, w[12], w[6:2]}, 5);
		cmd = `RVC_UCMD_INVOP;
		ixt = '0;
		u = '0;
		u.regN = `RVC_GR_ZZR;
		u.regM = `RVC_GR_ZZR;
		u.regO = `RVC_GR_ZZR;
		case (w[1:0])
			2'b00: begin
				case (w[15:13])
					3'b000: begin
						cmd = `RVC_UCMD_ALU3;
						ixt = {3'b001, `RVC_UCIX_ADD};
						u.regN = rd;
						u.regM = rd;
						u.regO = `RVC_GR_IMM;
						u.imm = alu6;
					end
					3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111: begin
						cmd = w[15] ? `RVC_UCMD_MOV_RM : `RVC_UCMD_MOV_MR;
						ixt = {3'b001, (w[14:13] == 2'b10) ? 2'b10 : 2'b11, 4'b0};
						u.regN = w[15] ? c42 : c97; // store swaps base and data
						u.regM = w[15] ? c97 : c42;
						u.regO = `RVC_GR_IMM;
						if (w[14:13] == 2'b10)
							u.imm = (w[5] << 6) | (w[12:10] << 3) | (w[6] << 2);
						else
							u.imm = (w[6:5] << 6) | (w[12:10] << 3);
					end
					default: ; // reserved
				endcase
			end
			2'b01: begin
				case (w[15:13])
					3'b000, 3'b001, 3'b010: begin
						cmd = (w[14:13] == 2'b10) ? `RVC_UCMD_MOV_IR : `RVC_UCMD_ALU3;
						ixt = {3'b001, (w[14:13] == 2'b00) ? `RVC_UCIX_ADD :
							(w[14:13] == 2'b01) ? `RVC_UCIX_ADDSL : `RVC_UCIX_LDIX};
						u.regN = rd;
						u.regM = rd;
						u.regO = `RVC_GR_IMM;
						u.imm = alu6;
					end
					3'b011: begin
						u.regN = rd;
						u.regM = rd;
						u.regO = `RVC_GR_IMM;
						if (w[11:7] == 5'd2) begin // stack adjust
							cmd = `RVC_UCMD_ALU3;
							ixt = {3'b001, `RVC_UCIX_ADD};
							raw = (w[12] << 9) | (w[4:3] << 7) | (w[5] << 6) | (w[2] << 5) |
								(w[6] << 4);
							u.imm = signExt(raw, 9);
						end else begin
							cmd = `RVC_UCMD_MOV_IR;
							ixt = {3'b001, `RVC_UCIX_LDIX};
							u.imm = alu6 << 12;
						end
					end
					3'b100: begin
						if (w[12:10] == 3'b011 || (w[12:10] == 3'b111 && !w[6])) begin
							cmd = `RVC_UCMD_ALU3;
							if (w[12])
								ixt = {3'b001, w[5] ? `RVC_UCIX_ADDSL : `RVC_UCIX_SUBSL};
							else
								ixt = {3'b001, (w[6:5] == 2'b00) ? `RVC_UCIX_SUB :
									(w[6:5] == 2'b01) ? `RVC_UCIX_XOR :
									(w[6:5] == 2'b10) ? `RVC_UCIX_OR : `RVC_UCIX_AND};
							u.regN = c97;
							u.regM = c97;
							u.regO = c42;
						end else if (w[11:10] == 2'b10) begin // andi
							cmd = `RVC_UCMD_ALU3;
							ixt = {3'b001, `RVC_UCIX_AND};
							u.regN = c97;
							u.regM = c97;
							u.regO = `RVC_GR_IMM;
							u.imm = alu6;
						end
					end
					3'b101: begin
						cmd = `RVC_UCMD_BRA;
						ixt = 9'b001_01_1_001;
						u.regM = `RVC_GR_BPC;
						u.regO = `RVC_GR_IMM;
						raw = (w[12] << 11) | (w[11] << 4) | (w[10:9] << 8) | (w[8] << 10) |
							(w[7] << 6) | (w[6] << 7) | (w[5:3] << 1) | (w[2] << 5);
						raw = signExt(raw, 11);
						u.imm = {raw[32], raw[32:1]}; // carried halved
					end
					default: begin // beqz, bnez
						cmd = `RVC_UCMD_JCMP;
						ixt = 9'b001_01_1_001;
						u.regM = c97;
						raw = (w[12] << 8) | (w[11:10] << 3) | (w[6:5] << 6) | (w[4:3] << 1) |
							(w[2] << 5);
						raw = signExt(raw, 8);
						u.imm = {raw[32], raw[32:1]};
					end
				endcase
			end
			2'b10: begin
				case (w[15:13])
					3'b000: ; // not decoded
					3'b100: begin
						if (w[6:2] != 5'd0) begin
							cmd = w[12] ? `RVC_UCMD_ALU3 : `RVC_UCMD_MOV_IR;
							ixt = {3'b001, w[12] ? `RVC_UCIX_ADD : `RVC_UCIX_LDIX};
							u.regN = rd;
							u.regM = rd;
							u.regO = rs2;
						end else if (w[11:7] != 5'd0) begin
							cmd = w[12] ? `RVC_UCMD_JSR : `RVC_UCMD_JMP;
							ixt = {3'b001, w[12] ? `RVC_UCIX_ADD : `RVC_UCIX_LDIX};
							u.regN = `RVC_GR_LR;
							u.regM = rd;
						end else begin
							cmd = `RVC_UCMD_OP_IXT;
							ixt = {3'b001, `RVC_UCIX_IXT_SYSE};
						end
					end
					default: begin // sp-relative loads and stores
						cmd = w[15] ? `RVC_UCMD_MOV_RM : `RVC_UCMD_MOV_MR;
						ixt = {3'b001, (w[14:13] == 2'b10) ? 2'b10 : 2'b11, 4'b0};
						u.regN = w[15] ? rs2 : rd;
						u.regM = `RVC_GR_SP;
						u.regO = `RVC_GR_IMM;
						case ({w[15], w[14:13] == 2'b10})
							2'b01: u.imm = (w[3:2] << 6) | (w[12] << 5) | (w[6:4] << 2);
							2'b00: u.imm = (w[4:2] << 6) | (w[12] << 5) | (w[6:5] << 3);
							2'b11: u.imm = (w[8:7] << 6) | (w[12:9] << 2);
							default: u.imm = (w[9:7] << 6) | (w[12:10] << 3);
						endcase
					end
				endcase
			end
			default: begin // quadrant 3
				cmd = `RVC_UCMD_NOP;
				ixt = 9'b001_000000;
			end
		endcase
		u.uCmd = {3'b000, cmd};
		u.uIxt = ixt;
		return u;
	endfunction

	task automatic checkEq(input logic [71:0] got, input logic [71:0] exp, input string msg);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic stepReady();
		outReady = (randBits(2) != 2'b00) && !holdOut;
	endtask

	// hold the word until the DUT takes it
	task automatic sendWord(input logic [15:0] w);
		int cycles;
		logic taken;
		inValid = 1'b1;
		inWord = w;
		cycles = 0;
		taken = 1'b0;
		while (!taken && !timedOut) begin
			@(posedge clock);
			taken = inReady;
			if (taken) begin
				expQ.push_back(model(w));
				sent++;
			end
			#1;
			stepReady();
			cycles++;
			if (!taken && cycles > waitLimit) begin
				$display("timeout: input word %h never accepted", w);
				timedOut = 1'b1;
			end
		end
		inValid = 1'b0;
	endtask

	// let every expected micro-op come out
	task automatic drainOutputs();
		int cycles;
		outReady = 1'b1;
		cycles = 0;
		while (expQ.size() != 0 && !timedOut) begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > waitLimit) begin
				$display("timeout: %0d micro-ops never came out", expQ.size());
				timedOut = 1'b1;
			end
		end
	endtask

	always @(posedge clock) begin
		if (rstN) begin
			if (inFlight >= maxInFlight)
				checkEq(72'(inReady), 72'(0), "inReady high with the pipeline full");
			if (outValid && outReady) begin
				received++;
				if (expQ.size() == 0) begin
					errors++;
					$display("output at %0t with no expected micro-op", $time);
				end else begin
					checkEq(uop, expQ.pop_front(), "micro-op mismatch");
				end
			end
			if (inValid && inReady)
				inFlight++;
			if (outValid && outReady)
				inFlight--;
		end
	end

	initial begin
		logic [15:0] directed [14];
		directed = '{16'hFFFF, 16'h8000, 16'h8D09, 16'h4108, 16'hC108, 16'h4082, 16'hC006,
			16'hA001, 16'hC101, 16'h6105, 16'h6285, 16'h8082, 16'h9002, 16'h9486};
		clock = 1'b0;
		rstN = 1'b0;
		inValid = 1'b0;
		inWord = '0;
		outReady = 1'b1;
		repeat (4) @(posedge clock);
		#1 rstN = 1'b1;
		repeat (3) begin
			@(posedge clock);
			checkEq(72'(outValid), 72'(0), "outValid high before any input");
		end
		#1;
		foreach (directed[i]) begin
			if (!timedOut)
				sendWord(directed[i]);
		end
		// fill every stage while the output is stalled
		drainOutputs();
		holdOut = 1'b1;
		outReady = 1'b0;
		for (int i = 0; i < maxInFlight && !timedOut; i++)
			sendWord(randBits(16));
		if (!timedOut) begin
			repeat (2) @(posedge clock);
			#1;
		end
		holdOut = 1'b0;
		for (int i = 0; i < numRandom && !timedOut; i++) begin
			if (randBits(2) == 2'b00) begin // idle gap
				@(posedge clock);
				#1 stepReady();
			end
			sendWord(randBits(16));
		end
		drainOutputs();
		if (!timedOut) begin
			@(posedge clock);
			checkEq(72'(received), 72'(sent), "output count differs from input count");
		end
		$display("errors: %0d, words sent %0d, micro-ops received %0d", errors, sent, received);
		if (errors == 0 && !timedOut)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== sim/rvcDecode_properties.sv ====
// handshake assertions bound to the decoder top level
`timescale 1ns/10ps

module rvcDecodeProps (
	input logic clock,
	input logic rstN,
	input logic clsValid,
	input logic clsReady,
	input rvcDecodePkg::rvcClassS cls,
	input logic outValid,
	input logic outReady,
	input rvcDecodePkg::rvcUopS uop
);

	// output register empty once reset is seen
	outLowAfterReset: assert property (@(posedge clock) !rstN |=> !outValid)
		else $error("outValid high right after reset");

	stallStable: assert property (@(posedge clock) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(uop))
		else $error("output changed while stalled");

	// a held producer word must survive until the FIFO has room
	producerHold: assert property (@(posedge clock) disable iff (!rstN)
		clsValid && !clsReady |=> clsValid && $stable(cls))
		else $error("producer word lost or changed while the FIFO was full");

endmodule

bind rvcDecodeTop rvcDecodeProps props (.*);

// ==== src/rvcClassify.sv ====
// producer stage: opcode pattern match into class fields
// and the output register that holds one classified word
`timescale 1ns/10ps
`include "rvcDecode_params.svh"

module rvcClassify (
	input logic clock,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input rvcDecodePkg::rvcWordU inWord,
	output logic clsValid,
	input logic clsReady,
	output rvcDecodePkg::rvcClassS cls
);

	rvcDecodePkg::rvcClassS dec;

	function automatic rvcDecodePkg::rvcClassS mkCls(
		input logic [5:0] nmid,
		input logic [4:0] fmid,
		input logic [5:0] ucmdIx,
		input logic [3:0] ity,
		input logic [2:0] bty
	);
		rvcDecodePkg::rvcClassS c;
		c = '0;
		c.nmid = nmid;
		c.fmid = fmid;
		c.ucmdIx = ucmdIx;
		c.ity = ity;
		c.bty = bty;
		return c;
	endfunction

	always_comb begin
		casez (inWord)
			// quadrant 0, funct3=100 is reserved and falls to default
			16'b000_???_???_??_???_00:
				dec = mkCls(`RVC_UCMD_ALU3, `RVC_FMID_IMM8REG, `RVC_UCIX_ADD, `RVC_ITY_SB, '0);
			16'b010_???_???_??_???_00:
				dec = mkCls(`RVC_UCMD_MOV_MR, `RVC_FMID_LDREGDISPREG, '0, `RVC_ITY_SB, `RVC_BTY_SW);
			16'b0?1_???_???_??_???_00:
				dec = mkCls(`RVC_UCMD_MOV_MR, `RVC_FMID_LDREGDISPREG, '0, `RVC_ITY_SB, `RVC_BTY_SQ);
			16'b110_???_???_??_???_00:
				dec = mkCls(`RVC_UCMD_MOV_RM, `RVC_FMID_LDREGDISPREG, '0, `RVC_ITY_UB, `RVC_BTY_SW);
			16'b1?1_???_???_??_???_00:
				dec = mkCls(`RVC_UCMD_MOV_RM, `RVC_FMID_LDREGDISPREG, '0, `RVC_ITY_UB, `RVC_BTY_SQ);

			16'b000_???_???_??_???_01:
				dec = mkCls(`RVC_UCMD_ALU3, `RVC_FMID_IMM8REG, `RVC_UCIX_ADD, `RVC_ITY_SB, '0);
			16'b001_???_???_??_???_01:
				dec = mkCls(`RVC_UCMD_ALU3, `RVC_FMID_IMM8REG, `RVC_UCIX_ADDSL, `RVC_ITY_SB, '0);
			16'b010_???_???_??_???_01:
				dec = mkCls(`RVC_UCMD_MOV_IR, `RVC_FMID_IMM8REG, `RVC_UCIX_LDIX, `RVC_ITY_SB, '0);
			16'b011_???_???_??_???_01: begin
				if (inWord.full.rd == 5'd2) // stack adjust
					dec = mkCls(`RVC_UCMD_ALU3, `RVC_FMID_IMM8REG, `RVC_UCIX_ADD,
						`RVC_ITY_UB, '0);
				else
					dec = mkCls(`RVC_UCMD_MOV_IR, `RVC_FMID_IMM8REG, `RVC_UCIX_LDIX,
						`RVC_ITY_SW, '0);
			end
			16'b100_011_???_00_???_01:
				dec = mkCls(`RVC_UCMD_ALU3, `RVC_FMID_REGREG, `RVC_UCIX_SUB, `RVC_ITY_UB, '0);
			16'b100_011_???_01_???_01:
				dec = mkCls(`RVC_UCMD_ALU3, `RVC_FMID_REGREG, `RVC_UCIX_XOR, `RVC_ITY_UB, '0);
			16'b100_011_???_10_???_01:
				dec = mkCls(`RVC_UCMD_ALU3, `RVC_FMID_REGREG, `RVC_UCIX_OR, `RVC_ITY_UB, '0);
			16'b100_011_???_11_???_01:
				dec = mkCls(`RVC_UCMD_ALU3, `RVC_FMID_REGREG, `RVC_UCIX_AND, `RVC_ITY_UB, '0);
			16'b100_?10_???_??_???_01: // and with immediate
				dec = mkCls(`RVC_UCMD_ALU3, `RVC_FMID_IMM8REG, `RVC_UCIX_AND, `RVC_ITY_UW, '0);
			16'b100_111_???_00_???_01:
				dec = mkCls(`RVC_UCMD_ALU3, `RVC_FMID_REGREG, `RVC_UCIX_SUBSL, `RVC_ITY_UB, '0);
			16'b100_111_???_01_???_01:
				dec = mkCls(`RVC_UCMD_ALU3, `RVC_FMID_REGREG, `RVC_UCIX_ADDSL, `RVC_ITY_UB, '0);
			16'b101_???_???_??_???_01:
				dec = mkCls(`RVC_UCMD_BRA, `RVC_FMID_PCDISP8, '0, `RVC_ITY_SB, '0);
			16'b110_???_???_??_???_01:
				dec = mkCls(`RVC_UCMD_JCMP, `RVC_FMID_REGPC, `RVC_UCIX_JCMP_QEQ, `RVC_ITY_UW, '0);
			16'b111_???_???_??_???_01:
				dec = mkCls(`RVC_UCMD_JCMP, `RVC_FMID_REGPC, `RVC_UCIX_JCMP_QNE, `RVC_ITY_UW, '0);

			16'b010_???_???_??_???_10:
				dec = mkCls(`RVC_UCMD_MOV_MR, `RVC_FMID_LDDI4SPREG, '0, `RVC_ITY_SB, `RVC_BTY_SW);
			16'b0?1_???_???_??_???_10:
				dec = mkCls(`RVC_UCMD_MOV_MR, `RVC_FMID_LDDI4SPREG, '0, `RVC_ITY_SB, `RVC_BTY_SQ);
			16'b100_???_???_??_???_10: begin
				// bit12 picks add over move, rs2=0 makes it a jump
				if (inWord.full.rs2 != 5'd0)
					dec = inWord.full.bit12 ?
						mkCls(`RVC_UCMD_ALU3, `RVC_FMID_REGREG, `RVC_UCIX_ADD, `RVC_ITY_SB, '0) :
						mkCls(`RVC_UCMD_MOV_IR, `RVC_FMID_REGREG, `RVC_UCIX_LDIX, `RVC_ITY_SB, '0);
				else if (inWord.full.rd != 5'd0)
					dec = inWord.full.bit12 ?
						mkCls(`RVC_UCMD_JSR, `RVC_FMID_REG, `RVC_UCIX_ADD, `RVC_ITY_SB, '0) :
						mkCls(`RVC_UCMD_JMP, `RVC_FMID_REG, `RVC_UCIX_LDIX, `RVC_ITY_SB, '0);
				else
					dec = mkCls(`RVC_UCMD_OP_IXT, `RVC_FMID_Z, `RVC_UCIX_IXT_SYSE,
						`RVC_ITY_SB, '0);
			end
			16'b110_???_???_??_???_10:
				dec = mkCls(`RVC_UCMD_MOV_RM, `RVC_FMID_LDDI4SPREG, '0, `RVC_ITY_UB, `RVC_BTY_SW);
			16'b1?1_???_???_??_???_10:
				dec = mkCls(`RVC_UCMD_MOV_RM, `RVC_FMID_LDDI4SPREG, '0, `RVC_ITY_UB, `RVC_BTY_SQ);

			16'b???_???_???_??_???_11: // 32-bit space, not handled here
				dec = mkCls(`RVC_UCMD_NOP, `RVC_FMID_Z, '0, `RVC_ITY_SB, '0);
			default:
				dec = mkCls(`RVC_UCMD_INVOP, `RVC_FMID_INV, '0, `RVC_ITY_SB, '0);
		endcase
		dec.word = inWord;
	end

	assign inReady = !clsValid || clsReady;

	always_ff @(posedge clock) begin
		if (!rstN)
			clsValid <= 1'b0;
		else if (inReady)
			clsValid <= inValid;
	end

	always_ff @(posedge clock) begin
		if (inValid && inReady)
			cls <= dec;
	end

endmodule

// ==== src/rvcDecodeTop.sv ====
// top level: producer, FIFO and consumer in a chain
`timescale 1ns/10ps

module rvcDecodeTop (
	input logic clock,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input rvcDecodePkg::rvcWordU inWord,
	output logic outValid,
	input logic outReady,
	output rvcDecodePkg::rvcUopS uop
);

	logic clsValid;
	logic clsReady;
	rvcDecodePkg::rvcClassS cls;
	logic qValid;
	logic qReady;
	rvcDecodePkg::rvcClassS qHead;

	rvcClassify classify (
		.clock(clock),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inWord(inWord),
		.clsValid(clsValid),
		.clsReady(clsReady),
		.cls(cls)
	);

	rvcOpFifo opFifo (
		.clock(clock),
		.rstN(rstN),
		.clsValid(clsValid),
		.clsReady(clsReady),
		.cls(cls),
		.qValid(qValid),
		.qReady(qReady),
		.qHead(qHead)
	);

	rvcOperandForm operandForm (
		.clock(clock),
		.rstN(rstN),
		.qValid(qValid),
		.qReady(qReady),
		.qHead(qHead),
		.outValid(outValid),
		.outReady(outReady),
		.uop(uop)
	);

endmodule

// ==== src/rvcOpFifo.sv ====
// circular FIFO of classified words between producer and consumer
`timescale 1ns/10ps
`include "rvcDecode_params.svh"

module rvcOpFifo (
	input logic clock,
	input logic rstN,
	input logic clsValid,
	output logic clsReady,
	input rvcDecodePkg::rvcClassS cls,
	output logic qValid,
	input logic qReady,
	output rvcDecodePkg::rvcClassS qHead
);

	localparam int depth = `RVC_FIFO_DEPTH;
	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntW = $clog2(depth + 1);

	rvcDecodePkg::rvcClassS mem [depth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic doWrite;
	logic doRead;

	function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] p);
		return (p == ptrW'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign clsReady = (count != cntW'(depth));
	assign qValid = (count != '0);
	assign qHead = mem[rdPtr];
	assign doWrite = clsValid && clsReady;
	assign doRead = qValid && qReady;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite)
				wrPtr <= nextPtr(wrPtr);
			if (doRead)
				rdPtr <= nextPtr(rdPtr);
			if (doWrite && !doRead)
				count <= count + 1'b1;
			else if (doRead && !doWrite)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (doWrite)
			mem[wrPtr] <= cls;
	end

endmodule
